// ==== hdl/disc_pkg.sv ====
/* Sizes and types shared by the discriminator.
   trigger_source 0..CHANNELS-1 selects a channel detector, the higher
   values select ext_trig_i. Delays and the hold count are in input beats. */

`default_nettype none

package disc_pkg;

  localparam int CHANNELS     = 4;
  localparam int SAMPLE_WIDTH = 16;
  localparam int EXT_TRIGGERS = 2;
  localparam int TRIG_SOURCES = CHANNELS + EXT_TRIGGERS;
  localparam int SRC_WIDTH    = $clog2(TRIG_SOURCES);
  localparam int MAX_DELAY    = 16;
  localparam int DELAY_WIDTH  = $clog2(MAX_DELAY);
  localparam int TSTAMP_WIDTH = 16; // wraps

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [TSTAMP_WIDTH-1:0] tstamp_t;

  typedef struct packed {
    sample_t                low_threshold;
    sample_t                high_threshold;
    logic [DELAY_WIDTH-1:0] start_delay;   // trigger delay
    logic [DELAY_WIDTH-1:0] stop_delay;    // hold after trigger falls
    logic [DELAY_WIDTH-1:0] digital_delay; // data delay, pre-trigger samples
    logic [SRC_WIDTH-1:0]   trigger_source;
  } chan_cfg_t;

  typedef struct packed {
    chan_cfg_t [CHANNELS-1:0] chan;
    logic [CHANNELS-1:0]      disable_mask; // 1 keeps every sample
  } disc_cfg_t;

  typedef struct packed {
    sample_t [CHANNELS-1:0] sample;
  } adc_beat_t;

  typedef struct packed {
    sample_t sample;
    tstamp_t tstamp; // input sample index
  } kept_sample_t;

endpackage

`default_nettype wire

// ==== hdl/threshold_detector.sv ====
/* Hysteresis comparator per channel, one cycle of latency.
   The state only moves on valid beats and holds between them.
   Thresholds are signed and low must not exceed high. */

`default_nettype none

module threshold_detector (
  input  wire logic                                      adc_clk,
  input  wire logic                                      rst_i,
  input  wire disc_pkg::adc_beat_t                       beat_i,
  input  wire logic                                      valid_i,
  input  wire disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] low_i,
  input  wire disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] high_i,
  output logic [disc_pkg::CHANNELS-1:0]                  trig_o
);

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      trig_o <= '0;
    end else if (valid_i) begin
      for (int ch = 0; ch < disc_pkg::CHANNELS; ch++) begin
        if ($signed(beat_i.sample[ch]) > $signed(high_i[ch])) begin
          trig_o[ch] <= 1'b1;
        end else if ($signed(beat_i.sample[ch]) < $signed(low_i[ch])) begin
          trig_o[ch] <= 1'b0;
        end
        // between the thresholds the state holds
      end
    end
  end

  for (genvar ch = 0; ch < disc_pkg::CHANNELS; ch++) begin : g_chk
    // an inverted window would make the trigger depend on compare order
    a_thr_order: assert property (
      @(posedge adc_clk) disable iff (rst_i)
      valid_i |-> $signed(low_i[ch]) <= $signed(high_i[ch])
    );
  end

endmodule

`default_nettype wire

// ==== hdl/delay_line.sv ====
/* Tap-selectable delay in beats, registered output updated on each beat.
   delay_i of 0 gives the current beat, n gives the beat n earlier.
   All taps clear on reset. */

`default_nettype none

module delay_line #(
  parameter type payload_t = logic
) (
  input  wire logic                             adc_clk,
  input  wire logic                             rst_i,
  input  wire logic                             shift_i,
  input  wire logic [disc_pkg::DELAY_WIDTH-1:0] delay_i,
  input  wire payload_t                         data_i,
  output payload_t                              data_o
);

  localparam int TAPS = disc_pkg::MAX_DELAY;

  payload_t sr_q [TAPS-1]; // older beats, sr_q[0] is the previous one
  payload_t taps [TAPS];

  always_comb begin
    taps[0] = data_i;
    for (int i = 1; i < TAPS; i++) begin
      taps[i] = sr_q[i-1];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int i = 0; i < TAPS - 1; i++) begin
        sr_q[i] <= '0;
      end
      data_o <= '0;
    end else if (shift_i) begin
      sr_q[0] <= data_i;
      for (int i = 1; i < TAPS - 1; i++) begin
        sr_q[i] <= sr_q[i-1];
      end
      data_o <= taps[delay_i];
    end
  end

  a_delay_range: assert property (
    @(posedge adc_clk) disable iff (rst_i)
    shift_i |-> int'(delay_i) < disc_pkg::MAX_DELAY
  );

endmodule

`default_nettype wire

// ==== hdl/hold_timer.sv ====
/* Down-counter for the stop delay, counted in beats.
   expired_o comes from the register, so a load shows one cycle later.
   Zero is the idle state after reset. */

`default_nettype none

module hold_timer (
  input  wire logic                             adc_clk,
  input  wire logic                             rst_i,
  input  wire logic                             load_i,
  input  wire logic                             count_i,
  input  wire logic [disc_pkg::DELAY_WIDTH-1:0] value_i,
  output logic                                  expired_o
);

  logic [disc_pkg::DELAY_WIDTH-1:0] count_q;

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= value_i;
    end else if (count_i && count_q != '0) begin
      count_q <= count_q - 1'b1; // stops at zero
    end
  end

  assign expired_o = (count_q == '0);

  a_load_xor_count: assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !(load_i && count_i)
  );

endmodule

`default_nettype wire

// ==== hdl/gate_fsm.sv ====
/* Keep gate control, gate_o is combinational and valid on beat_i.
   The hold timer is loaded with stop_delay-1 on the falling beat, since
   that beat already belongs to the hold window. */

`default_nettype none

module gate_fsm (
  input  wire logic adc_clk,
  input  wire logic rst_i,
  input  wire logic beat_i,
  input  wire logic trig_i,            // trigger after start delay
  input  wire logic stop_delay_zero_i,
  input  wire logic expired_i,
  output logic      load_o,
  output logic      count_o,
  output logic      gate_o
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    OPEN = 2'd1,
    HOLD = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (trig_i) state_d = OPEN;
      end
      OPEN: begin
        if (!trig_i) begin
          state_d = stop_delay_zero_i ? IDLE : HOLD;
        end
      end
      HOLD: begin
        if (trig_i) begin
          state_d = OPEN; // retrigger
        end else if (expired_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else if (beat_i) begin
      state_q <= state_d;
    end
  end

  assign gate_o = trig_i
                | (state_q == OPEN && !stop_delay_zero_i)
                | (state_q == HOLD && !expired_i);

  assign load_o  = beat_i && state_q == OPEN && !trig_i && !stop_delay_zero_i;
  assign count_o = beat_i && state_q == HOLD && !trig_i && !expired_i;

  a_state_legal: assert property (
    @(posedge adc_clk) disable iff (rst_i)
    state_q inside {IDLE, OPEN, HOLD}
  );

endmodule

`default_nettype wire

// ==== hdl/channel_discriminator.sv ====
/* One channel: trigger, data and timestamp delays, gate and output register.
   Two cycles from beat_i to kept_valid_o. Entries from before the first beat
   are never emitted, whether the channel is gated or disabled. */

`default_nettype none

module channel_discriminator (
  input  wire logic                adc_clk,
  input  wire logic                rst_i,
  input  wire logic                beat_i,
  input  wire disc_pkg::sample_t   sample_i,
  input  wire disc_pkg::tstamp_t   tstamp_i,
  input  wire logic                trig_i,
  input  wire disc_pkg::chan_cfg_t cfg_i,
  input  wire logic                disable_i,
  output disc_pkg::kept_sample_t   kept_o,
  output logic                     kept_valid_o
);

  logic beat_d;
  logic trig_dly;
  disc_pkg::sample_t sample_dly;
  disc_pkg::tstamp_t tstamp_dly;
  logic [disc_pkg::DELAY_WIDTH-1:0] fill_q; // beats seen, saturating
  logic [disc_pkg::DELAY_WIDTH-1:0] hold_value;
  logic stop_zero;
  logic load;
  logic count;
  logic expired;
  logic gate;
  logic data_ok;

  delay_line #(.payload_t(logic)) u_trig_dly (
    .adc_clk, .rst_i, .shift_i(beat_i), .delay_i(cfg_i.start_delay),
    .data_i(trig_i), .data_o(trig_dly)
  );

  delay_line #(.payload_t(disc_pkg::sample_t)) u_sample_dly (
    .adc_clk, .rst_i, .shift_i(beat_i), .delay_i(cfg_i.digital_delay),
    .data_i(sample_i), .data_o(sample_dly)
  );

  delay_line #(.payload_t(disc_pkg::tstamp_t)) u_tstamp_dly (
    .adc_clk, .rst_i, .shift_i(beat_i), .delay_i(cfg_i.digital_delay),
    .data_i(tstamp_i), .data_o(tstamp_dly)
  );

  assign stop_zero  = (cfg_i.stop_delay == '0);
  assign hold_value = cfg_i.stop_delay - 1'b1; // falling beat counts as one

  hold_timer u_hold (
    .adc_clk, .rst_i, .load_i(load), .count_i(count),
    .value_i(hold_value), .expired_o(expired)
  );

  gate_fsm u_gate (
    .adc_clk, .rst_i, .beat_i(beat_d), .trig_i(trig_dly),
    .stop_delay_zero_i(stop_zero), .expired_i(expired),
    .load_o(load), .count_o(count), .gate_o(gate)
  );

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      beat_d <= 1'b0;
      fill_q <= '0;
    end else begin
      beat_d <= beat_i;
      if (beat_d && fill_q != disc_pkg::DELAY_WIDTH'(disc_pkg::MAX_DELAY - 1)) begin
        fill_q <= fill_q + 1'b1;
      end
    end
  end

  assign data_ok = (fill_q >= cfg_i.digital_delay);

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      kept_valid_o <= 1'b0;
    end else begin
      kept_valid_o <= beat_d && data_ok && (gate || disable_i);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (beat_d) begin
      kept_o.sample <= sample_dly;
      kept_o.tstamp <= tstamp_dly;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sample_discriminator.sv ====
/* Multi-channel sample discriminator, kept_valid_o follows adc_valid_i by 3 cycles.
   Configuration loads on cfg_valid_i and must only change while idle and drained.
   Timestamps number input beats from 0 after reset and wrap. No back-pressure. */

`default_nettype none

module sample_discriminator (
  input  wire logic                                 adc_clk,
  input  wire logic                                 rst_i,
  input  wire disc_pkg::adc_beat_t                  adc_beat_i,
  input  wire logic                                 adc_valid_i,
  input  wire logic [disc_pkg::EXT_TRIGGERS-1:0]    ext_trig_i,
  input  wire disc_pkg::disc_cfg_t                  cfg_i,
  input  wire logic                                 cfg_valid_i,
  output disc_pkg::kept_sample_t [disc_pkg::CHANNELS-1:0] kept_o,
  output logic [disc_pkg::CHANNELS-1:0]             kept_valid_o
);

  disc_pkg::disc_cfg_t cfg_q;
  disc_pkg::adc_beat_t beat_q;
  logic valid_q;
  logic [disc_pkg::EXT_TRIGGERS-1:0] ext_q;
  disc_pkg::tstamp_t count_q;
  disc_pkg::tstamp_t tstamp_q;
  logic [disc_pkg::CHANNELS-1:0] det_trig;
  logic [disc_pkg::TRIG_SOURCES-1:0] sources;
  logic [disc_pkg::CHANNELS-1:0] sel_trig;
  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] low_thr;
  disc_pkg::sample_t [disc_pkg::CHANNELS-1:0] high_thr;

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      cfg_q   <= '0; // all channels enabled
      valid_q <= 1'b0;
      ext_q   <= '0;
      count_q <= '0;
    end else begin
      if (cfg_valid_i) cfg_q <= cfg_i;
      valid_q <= adc_valid_i;
      if (adc_valid_i) begin
        ext_q   <= ext_trig_i; // sampled with the data
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_valid_i) begin
      beat_q   <= adc_beat_i;
      tstamp_q <= count_q;
    end
  end

  threshold_detector u_det (
    .adc_clk, .rst_i, .beat_i(adc_beat_i), .valid_i(adc_valid_i),
    .low_i(low_thr), .high_i(high_thr), .trig_o(det_trig)
  );

  assign sources = {ext_q, det_trig};

  for (genvar ch = 0; ch < disc_pkg::CHANNELS; ch++) begin : g_chan
    assign low_thr[ch]  = cfg_q.chan[ch].low_threshold;
    assign high_thr[ch] = cfg_q.chan[ch].high_threshold;
    assign sel_trig[ch] = sources[cfg_q.chan[ch].trigger_source];

    channel_discriminator u_chan (
      .adc_clk, .rst_i,
      .beat_i(valid_q),
      .sample_i(beat_q.sample[ch]),
      .tstamp_i(tstamp_q),
      .trig_i(sel_trig[ch]),
      .cfg_i(cfg_q.chan[ch]),
      .disable_i(cfg_q.disable_mask[ch]),
      .kept_o(kept_o[ch]),
      .kept_valid_o(kept_valid_o[ch])
    );

    a_src_range: assert property (
      @(posedge adc_clk) disable iff (rst_i)
      cfg_valid_i |-> int'(cfg_i.chan[ch].trigger_source) < disc_pkg::TRIG_SOURCES
    );
  end

endmodule

`default_nettype wire

// ==== verif/sample_discriminator_tb.sv ====
/* Directed testbench for sample_discriminator.
   Every run resets the DUT, loads one configuration, drives beats and checks
   the kept samples of each channel against a model of the gate rule. */

`default_nettype none

module sample_discriminator_tb;

  localparam int CH          = disc_pkg::CHANNELS;
  localparam int MAX_BEATS   = 64;
  localparam int LATENCY     = 3;
  localparam int TOTAL_BEATS = 32 + 40 + 32 + 30 + 45 + 4 * 60;
  localparam int CYCLE_LIMIT = TOTAL_BEATS * 2 + 200;

  logic                              adc_clk;
  logic                              rst_i;
  disc_pkg::adc_beat_t               adc_beat_i;
  logic                              adc_valid_i;
  logic [disc_pkg::EXT_TRIGGERS-1:0] ext_trig_i;
  disc_pkg::disc_cfg_t               cfg_i;
  logic                              cfg_valid_i;
  disc_pkg::kept_sample_t [CH-1:0]   kept_o;
  logic [CH-1:0]                     kept_valid_o;

  disc_pkg::adc_beat_t               beat_mem [MAX_BEATS];
  logic [disc_pkg::EXT_TRIGGERS-1:0] ext_mem [MAX_BEATS];
  disc_pkg::kept_sample_t            exp_q [CH][$]; // expected kept samples per channel
  int                                due_q [CH][$]; // beat that emits each of them
  int beat_hist [LATENCY]; // beat index sampled at recent edges, -1 for none
  int beat_no = 0;
  int errors = 0;
  int checks = 0;
  int tests  = 0;
  int cycles = 0;

  sample_discriminator uut (
    .adc_clk(adc_clk), .rst_i(rst_i), .adc_beat_i(adc_beat_i), .adc_valid_i(adc_valid_i),
    .ext_trig_i(ext_trig_i), .cfg_i(cfg_i), .cfg_valid_i(cfg_valid_i),
    .kept_o(kept_o), .kept_valid_o(kept_valid_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(posedge adc_clk) begin : beat_tracker
    for (int i = LATENCY - 1; i > 0; i--) begin
      beat_hist[i] <= beat_hist[i-1];
    end
    beat_hist[0] <= adc_valid_i ? beat_no : -1;
    if (rst_i) begin
      beat_no <= 0;
    end else if (adc_valid_i) begin
      beat_no <= beat_no + 1;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, want);
    end
  endtask

  always @(negedge adc_clk) begin : monitor
    disc_pkg::kept_sample_t want;
    int due;
    for (int ch = 0; ch < CH; ch++) begin
      if (kept_valid_o[ch]) begin
        if (exp_q[ch].size() == 0) begin
          errors++;
          $display("channel %0d kept a sample that the model drops", ch);
        end else begin
          want = exp_q[ch].pop_front();
          due = due_q[ch].pop_front();
          compare_value($sformatf("kept_o[%0d].sample", ch), 32'(kept_o[ch].sample),
                        32'(want.sample));
          compare_value($sformatf("kept_o[%0d].tstamp", ch), 32'(kept_o[ch].tstamp),
                        32'(want.tstamp));
          compare_value($sformatf("kept_valid_o[%0d] beat", ch),
                        32'(beat_hist[LATENCY-1]), 32'(due));
        end
      end
    end
  end

  // hysteresis, source select and gate window, all indexed by beat
  task automatic build_expected(input int n, input disc_pkg::disc_cfg_t cfg);
    logic det [CH][MAX_BEATS];
    logic src [MAX_BEATS];
    logic state;
    logic gate;
    disc_pkg::sample_t s;
    disc_pkg::sample_t lo;
    disc_pkg::sample_t hi;
    disc_pkg::kept_sample_t item;
    int sel;
    int dd;
    int first;
    int last;
    for (int ch = 0; ch < CH; ch++) begin
      lo = cfg.chan[ch].low_threshold;
      hi = cfg.chan[ch].high_threshold;
      state = 1'b0;
      for (int k = 0; k < n; k++) begin
        s = beat_mem[k].sample[ch];
        if (s > hi) begin
          state = 1'b1;
        end else if (s < lo) begin
          state = 1'b0;
        end
        det[ch][k] = state;
      end
    end
    for (int ch = 0; ch < CH; ch++) begin
      exp_q[ch].delete();
      due_q[ch].delete();
      sel = int'(cfg.chan[ch].trigger_source);
      dd = int'(cfg.chan[ch].digital_delay);
      for (int k = 0; k < n; k++) begin
        src[k] = (sel < CH) ? det[sel][k] : ext_mem[k][sel - CH];
      end
      for (int k = dd; k < n; k++) begin
        last = k - int'(cfg.chan[ch].start_delay);
        first = last - int'(cfg.chan[ch].stop_delay);
        gate = 1'b0;
        for (int j = (first < 0) ? 0 : first; j <= last; j++) begin
          gate |= src[j];
        end
        if (gate || cfg.disable_mask[ch]) begin
          item.sample = beat_mem[k - dd].sample[ch];
          item.tstamp = disc_pkg::tstamp_t'(k - dd);
          exp_q[ch].push_back(item);
          due_q[ch].push_back(k);
        end
      end
    end
  endtask

  task automatic run_case(input disc_pkg::disc_cfg_t cfg, input int n, input bit gaps);
    @(posedge adc_clk);
    rst_i <= 1'b1;
    repeat (3) @(posedge adc_clk);
    rst_i <= 1'b0;
    cfg_i <= cfg;
    cfg_valid_i <= 1'b1;
    @(posedge adc_clk);
    cfg_valid_i <= 1'b0;
    build_expected(n, cfg);
    for (int k = 0; k < n; k++) begin
      if (gaps && $urandom_range(0, 3) == 0) begin
        adc_valid_i <= 1'b0; // idle cycle between beats
        @(posedge adc_clk);
      end
      adc_valid_i <= 1'b1;
      adc_beat_i <= beat_mem[k];
      ext_trig_i <= ext_mem[k];
      @(posedge adc_clk);
    end
    adc_valid_i <= 1'b0;
    repeat (LATENCY + 1) @(posedge adc_clk);
    for (int ch = 0; ch < CH; ch++) begin
      if (exp_q[ch].size() != 0) begin
        errors++;
        $display("channel %0d never kept %0d expected samples", ch, exp_q[ch].size());
        exp_q[ch].delete();
        due_q[ch].delete();
      end
    end
  endtask

  function automatic disc_pkg::disc_cfg_t uniform_cfg(input int lo, input int hi,
      input int start, input int stop, input int dd);
    disc_pkg::disc_cfg_t cfg;
    cfg = '0;
    for (int ch = 0; ch < CH; ch++) begin
      cfg.chan[ch].low_threshold  = disc_pkg::sample_t'(lo);
      cfg.chan[ch].high_threshold = disc_pkg::sample_t'(hi);
      cfg.chan[ch].start_delay    = disc_pkg::DELAY_WIDTH'(start);
      cfg.chan[ch].stop_delay     = disc_pkg::DELAY_WIDTH'(stop);
      cfg.chan[ch].digital_delay  = disc_pkg::DELAY_WIDTH'(dd);
      cfg.chan[ch].trigger_source = disc_pkg::SRC_WIDTH'(ch); // own detector
    end
    return cfg;
  endfunction

  task automatic clear_stimulus();
    for (int k = 0; k < MAX_BEATS; k++) begin
      beat_mem[k] = '0;
      ext_mem[k] = '0;
    end
  endtask

  // small ramp inside the window plus one spike above and one below
  task automatic fill_pulse(input int n, input int ch, input int at);
    for (int k = 0; k < n; k++) begin
      beat_mem[k].sample[ch] = disc_pkg::sample_t'(k + 3 * ch);
    end
    beat_mem[at].sample[ch] = 16'sd500;
    beat_mem[at + 1].sample[ch] = -16'sd500;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %-16s %s, %0d errors", name, (errors == err_before) ? "ok" : "mismatch",
             errors - err_before);
  endtask

  task automatic disabled_channels();
    int e0;
    disc_pkg::disc_cfg_t cfg;
    e0 = errors;
    clear_stimulus();
    for (int k = 0; k < 32; k++) begin
      for (int ch = 0; ch < CH; ch++) begin
        beat_mem[k].sample[ch] = disc_pkg::sample_t'($urandom);
      end
    end
    cfg = uniform_cfg(0, 0, 0, 0, 0);
    cfg.disable_mask = '1;
    run_case(cfg, 32, 1'b0);
    finish_test("disabled", e0);
  endtask

  task automatic hysteresis_ramp();
    int e0;
    int v;
    e0 = errors;
    clear_stimulus();
    for (int k = 0; k < 40; k++) begin
      for (int ch = 0; ch < CH; ch++) begin
        if (k < 10) begin
          v = -200 + 40 * k; // rises past high
        end else if (k < 20) begin
          v = 50 - 10 * (k - 10); // between the thresholds
        end else if (k < 30) begin
          v = -150;
        end else begin
          v = 60;
        end
        beat_mem[k].sample[ch] = disc_pkg::sample_t'(v + 5 * ch);
      end
    end
    run_case(uniform_cfg(-100, 100, 0, 0, 0), 40, 1'b0);
    finish_test("hysteresis", e0);
  endtask

  task automatic start_stop_window();
    int e0;
    e0 = errors;
    clear_stimulus();
    for (int ch = 0; ch < CH; ch++) begin
      fill_pulse(32, ch, 10 + 2 * ch);
    end
    run_case(uniform_cfg(-100, 100, 3, 5, 0), 32, 1'b0);
    finish_test("start_stop", e0);
  endtask

  task automatic pretrigger_window();
    int e0;
    e0 = errors;
    clear_stimulus();
    for (int ch = 0; ch < CH; ch++) begin
      fill_pulse(30, ch, 12);
    end
    run_case(uniform_cfg(-100, 100, 0, 2, 4), 30, 1'b0);
    finish_test("digital_delay", e0);
  endtask

  task automatic trigger_sources();
    int e0;
    disc_pkg::disc_cfg_t cfg;
    e0 = errors;
    clear_stimulus();
    for (int ch = 0; ch < CH; ch++) begin
      fill_pulse(45, ch, 8);
    end
    beat_mem[11].sample[0] = 16'sd500; // retrigger inside the hold
    beat_mem[12].sample[0] = -16'sd500;
    ext_mem[20][0] = 1'b1;
    ext_mem[23][0] = 1'b1;
    for (int k = 30; k < 34; k++) begin
      ext_mem[k][1] = 1'b1;
    end
    cfg = uniform_cfg(-100, 100, 1, 4, 0);
    cfg.chan[1].trigger_source = disc_pkg::SRC_WIDTH'(0);
    cfg.chan[2].trigger_source = disc_pkg::SRC_WIDTH'(CH);
    cfg.chan[3].trigger_source = disc_pkg::SRC_WIDTH'(CH + 1);
    run_case(cfg, 45, 1'b0);
    finish_test("sources", e0);
  endtask

  task automatic random_configs();
    int e0;
    int lo;
    disc_pkg::disc_cfg_t cfg;
    e0 = errors;
    for (int r = 0; r < 4; r++) begin
      clear_stimulus();
      cfg = '0;
      for (int ch = 0; ch < CH; ch++) begin
        lo = int'($urandom_range(0, 3999)) - 2000;
        cfg.chan[ch].low_threshold  = disc_pkg::sample_t'(lo);
        cfg.chan[ch].high_threshold = disc_pkg::sample_t'(lo + int'($urandom_range(0, 3000)));
        cfg.chan[ch].start_delay    = disc_pkg::DELAY_WIDTH'($urandom_range(0, 15));
        cfg.chan[ch].stop_delay     = disc_pkg::DELAY_WIDTH'($urandom_range(0, 15));
        cfg.chan[ch].digital_delay  = disc_pkg::DELAY_WIDTH'($urandom_range(0, 15));
        cfg.chan[ch].trigger_source =
          disc_pkg::SRC_WIDTH'($urandom_range(0, disc_pkg::TRIG_SOURCES - 1));
      end
      cfg.disable_mask = CH'($urandom & $urandom); // mostly gated
      for (int k = 0; k < 60; k++) begin
        for (int ch = 0; ch < CH; ch++) begin
          beat_mem[k].sample[ch] = disc_pkg::sample_t'(int'($urandom_range(0, 7999)) - 4000);
        end
        ext_mem[k] = 2'($urandom) & 2'($urandom) & 2'($urandom);
      end
      run_case(cfg, 60, 1'b1);
    end
    finish_test("random", e0);
  endtask

  initial begin
    void'($urandom(32'hb713e54c));
    rst_i       <= 1'b1;
    adc_beat_i  <= '0;
    adc_valid_i <= 1'b0;
    ext_trig_i  <= '0;
    cfg_i       <= '0;
    cfg_valid_i <= 1'b0;
    disabled_channels();
    hysteresis_ramp();
    start_stop_window();
    pretrigger_window();
    trigger_sources();
    random_configs();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/disc_pkg.sv
hdl/threshold_detector.sv
hdl/delay_line.sv
hdl/hold_timer.sv
hdl/gate_fsm.sv
hdl/channel_discriminator.sv
hdl/sample_discriminator.sv
verif/sample_discriminator_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = sample_discriminator_tb
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
